/* list.f */
rtl/uart_line_pkg.sv
rtl/uart_bus_pkg.sv
rtl/uart_rx_sampler.sv
rtl/uart_rx_fifo.sv
rtl/uart_rx_regs.sv
rtl/uart_rx.sv
verification/tb_clock_gen.sv
verification/tb_uart_rx.sv

/* rtl/uart_bus_pkg.sv */
/*
 Register addresses, FIFO depth, bus request and response structs
 and the read-word union of the UART receiver.
*/
`default_nettype none

package uart_bus_pkg;

	localparam int FIFO_DEPTH = 8;

	localparam logic [1:0] ADDR_DATA = 2'd0;
	localparam logic [1:0] ADDR_STATUS = 2'd1;

	// Request and address stay stable until ready.
	typedef struct packed {
		logic request;
		logic [1:0] address;
	} bus_req_t;

	typedef struct packed {
		logic [28:0] zero;
		logic full;
		logic empty;
		logic rsvd;
	} rx_status_t;

	// Received byte as seen at the data address.
	typedef struct packed {
		logic [23:0] zero;
		logic [7:0] value;
	} rx_data_t;

	// One read word, decoded by address.
	typedef union packed {
		rx_data_t data;
		rx_status_t status;
	} rx_word_u;

	typedef struct packed {
		logic ready;
		rx_word_u rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* rtl/uart_line_pkg.sv */
/*
 Serial line timing, frame constants and the receive event struct
 of the UART receiver.
*/
`default_nettype none

package uart_line_pkg;

	// Samples taken per bit.
	localparam int OVERSAMPLE = 8;
	// Clocks per oversample tick, small for simulation.
	localparam int PRESCALE = 2;
	localparam int BIT_CLOCKS = OVERSAMPLE * PRESCALE;
	// Distance from the falling start edge to the middle of the start bit.
	localparam int HALF_BIT_CLOCKS = BIT_CLOCKS / 2;

	localparam int DATA_BITS = 8;
	localparam logic [7:0] SOFT_RESET_CHAR = 8'hff;

	// One-cycle pulses raised at the stop bit.
	typedef struct packed {
		logic interrupt;
		logic soft_reset;
	} rx_event_t;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
/*
 UART receiver top: line sampler, byte FIFO and bus read port.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input logic i_clock,
	input logic i_reset,
	input logic i_uart_rx,
	input uart_bus_pkg::bus_req_t i_bus_req,
	output uart_bus_pkg::bus_rsp_t o_bus_rsp,
	output uart_line_pkg::rx_event_t o_event
);
	import uart_bus_pkg::*;

	logic fifo_write;
	logic [7:0] fifo_wdata;
	logic fifo_read;
	logic [7:0] fifo_rdata;
	logic fifo_empty;
	logic fifo_full;

	uart_rx_sampler u_sampler (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_uart_rx(i_uart_rx),
		.i_fifo_full(fifo_full),
		.o_write(fifo_write),
		.o_byte(fifo_wdata),
		.o_event(o_event)
	);

	uart_rx_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(fifo_write),
		.i_wdata(fifo_wdata),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_empty(fifo_empty),
		.o_full(fifo_full)
	);

	uart_rx_regs u_regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_req(i_bus_req),
		.o_bus_rsp(o_bus_rsp),
		.o_read(fifo_read),
		.i_rdata(fifo_rdata),
		.i_empty(fifo_empty),
		.i_full(fifo_full)
	);

endmodule

`default_nettype wire

/* rtl/uart_rx_fifo.sv */
/*
 Byte FIFO with registered read data and empty and full flags.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo #(
	parameter int DEPTH = 8
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_write,
	input logic [7:0] i_wdata,
	input logic i_read,
	output logic [7:0] o_rdata,
	output logic o_empty,
	output logic o_full
);

	logic [7:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH + 1)-1:0] count;
	logic do_write;
	logic do_read;

	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	// Flags follow the count, so they change at the write or pop edge.
	assign o_empty = (count == '0);
	assign o_full = (count == ($clog2(DEPTH + 1))'(DEPTH));

	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (do_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end

			// Write and pop together keep the count.
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The read port checks empty one cycle before it pops.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_read |-> !o_empty);

	// The sampler withholds its strobe while full.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_write |-> !o_full);

endmodule

`default_nettype wire

/* rtl/uart_rx_regs.sv */
/*
 Bus read port: data register fed from the FIFO and the status word.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx_regs (
	input logic i_clock,
	input logic i_reset,
	input uart_bus_pkg::bus_req_t i_bus_req,
	output uart_bus_pkg::bus_rsp_t o_bus_rsp,
	output logic o_read,
	input logic [7:0] i_rdata,
	input logic i_empty,
	input logic i_full
);
	import uart_bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_POP,
		ST_WAIT,
		ST_HOLD
	} state_t;

	state_t state;
	rx_word_u rdata_q;

	// Ready falls together with request.
	assign o_bus_rsp = '{
		ready: (state == ST_HOLD) && i_bus_req.request,
		rdata: rdata_q
	};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_read <= 1'b0;
		end
		else begin
			o_read <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_bus_req.request) begin
						case (i_bus_req.address)
							ADDR_DATA: begin
								// Data read waits here until a byte is queued.
								if (!i_empty) begin
									o_read <= 1'b1;
									state <= ST_POP;
								end
							end
							ADDR_STATUS: begin
								rdata_q.status <= '{zero: '0, full: i_full,
									empty: i_empty, rsvd: 1'b0};
								state <= ST_HOLD;
							end
							default: begin
								rdata_q <= '0;
								state <= ST_HOLD;
							end
						endcase
					end
				end
				// FIFO takes the pop on this edge.
				ST_POP: state <= ST_WAIT;
				ST_WAIT: begin
					rdata_q.data <= '{zero: '0, value: i_rdata};
					state <= ST_HOLD;
				end
				ST_HOLD: begin
					if (!i_bus_req.request) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Ready only follows a request held since the previous cycle.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_rsp.ready |-> i_bus_req.request && $past(i_bus_req.request));

endmodule

`default_nettype wire

/* rtl/uart_rx_sampler.sv */
/*
 UART line sampler: input synchronizer, start bit search,
 data and stop bit sampling, FIFO write and event pulses.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler (
	input logic i_clock,
	input logic i_reset,
	input logic i_uart_rx,
	input logic i_fifo_full,
	output logic o_write,
	output logic [7:0] o_byte,
	output uart_line_pkg::rx_event_t o_event
);
	import uart_line_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic [$clog2(BIT_CLOCKS)-1:0] prescale;
	// 0 idle, top value start bit, then data bits, 1 stop bit.
	logic [$clog2(DATA_BITS + 3)-1:0] bit_index;
	logic [7:0] shift_reg;

	assign o_byte = shift_reg;

	// Two flops against metastability.
	// The line idles high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else begin
			rx_meta <= i_uart_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			bit_index <= '0;
			o_write <= 1'b0;
			o_event <= '0;
		end
		else begin
			o_write <= 1'b0;
			o_event <= '0;

			if (prescale != '0) begin
				prescale <= prescale - 1'b1;
			end
			else if (bit_index == '0) begin
				// Idle, wait for a falling line.
				if (!rx_sync) begin
					prescale <= ($clog2(BIT_CLOCKS))'(HALF_BIT_CLOCKS - 1);
					bit_index <= ($clog2(DATA_BITS + 3))'(DATA_BITS + 2);
				end
			end
			else if (bit_index == ($clog2(DATA_BITS + 3))'(DATA_BITS + 2)) begin
				// Middle of the start bit.
				if (!rx_sync) begin
					prescale <= ($clog2(BIT_CLOCKS))'(BIT_CLOCKS - 1);
					bit_index <= bit_index - 1'b1;
				end
				else begin
					bit_index <= '0;
				end
			end
			else if (bit_index > 1) begin
				// LSB arrives first.
				shift_reg <= {rx_sync, shift_reg[7:1]};
				prescale <= ($clog2(BIT_CLOCKS))'(BIT_CLOCKS - 1);
				bit_index <= bit_index - 1'b1;
			end
			else begin
				bit_index <= '0;
				// Frames with a low stop bit are dropped.
				if (rx_sync) begin
					o_write <= !i_fifo_full;
					o_event.interrupt <= 1'b1;
					o_event.soft_reset <= (shift_reg == SOFT_RESET_CHAR);
				end
			end
		end
	end

	// A frame takes many clocks, so writes are isolated pulses.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_write |=> !o_write);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
/*
 Free-running testbench clock.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 40
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever begin
			#(PERIOD / 2) o_clock = ~o_clock;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_uart_rx.sv */
/*
 UART receiver testbench: serial line driver, bus reads,
 FIFO reference model and checks.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;
	import uart_line_pkg::*;
	import uart_bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;

	logic clock;
	logic reset;
	logic uart_line;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	rx_event_t rx_event;

	// Bytes the DUT is expected to hold.
	logic [7:0] model_q[$];
	int irq_count = 0;
	int soft_count = 0;
	int irq_expected = 0;
	integer seed;
	string read_name;
	logic [31:0] read_expected;
	logic [31:0] read_actual;
	event read_done;

	tb_clock_gen #(.PERIOD(40)) u_clock (.o_clock(clock));

	uart_rx dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_uart_rx(uart_line),
		.i_bus_req(bus_req),
		.o_bus_rsp(bus_rsp),
		.o_event(rx_event)
	);

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic drive_edge();
		@(posedge clock);
		#2;
	endtask

	function automatic void model_push(input logic [7:0] value);
		// A full FIFO drops the byte.
		if (model_q.size() < FIFO_DEPTH) begin
			model_q.push_back(value);
		end
	endfunction

	// Expected read word for an address; a data read pops the model.
	function automatic logic [31:0] expected_read(input logic [1:0] address);
		logic [31:0] word;
		word = '0;
		if (address == ADDR_DATA) begin
			word[7:0] = model_q.pop_front();
		end
		else if (address == ADDR_STATUS) begin
			word[2] = (model_q.size() == FIFO_DEPTH);
			word[1] = (model_q.size() == 0);
		end
		return word;
	endfunction

	// Start, eight data bits LSB first and stop, then one idle bit.
	task automatic send_frame(input logic [7:0] value, input logic bad_stop);
		logic [9:0] bits;
		bits = {~bad_stop, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_line = bits[i];
			repeat (BIT_CLOCKS) drive_edge();
		end
		uart_line = 1'b1;
		repeat (BIT_CLOCKS) drive_edge();
		if (!bad_stop) begin
			model_push(value);
		end
	endtask

	task automatic bus_read(input string name, input logic [1:0] address);
		int cycles;
		cycles = 0;
		bus_req = '{request: 1'b1, address: address};
		@(negedge clock);
		while (!bus_rsp.ready) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				stop_on_error($sformatf("%s: no ready for the read of address %0d",
					name, address));
			end
			@(negedge clock);
		end
		read_name = name;
		read_actual = bus_rsp.rdata;
		read_expected = expected_read(address);
		->read_done;
		drive_edge();
		bus_req.request = 1'b0;
		drive_edge();
	endtask

	task automatic wait_interrupts(input string name, input int target);
		int cycles;
		cycles = 0;
		while (irq_count < target) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				stop_on_error($sformatf("%s: interrupt number %0d never came", name, target));
			end
			drive_edge();
		end
		drive_edge();
		check_value(name, target, irq_count);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
			else stop_on_error($sformatf("[FAIL] %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	// Compares each bus read with the model.
	always @(read_done) begin
		assert (read_actual === read_expected)
			else stop_on_error($sformatf("[FAIL] %s expected %h actual %h",
				read_name, read_expected, read_actual));
	end

	// Event pulses last one cycle.
	always @(negedge clock) begin
		if (!reset) begin
			irq_count += rx_event.interrupt;
			soft_count += rx_event.soft_reset;
		end
	end

	initial begin
		logic [7:0] value;
		int soft_base;
		seed = 32'hfa97_33b8;
		reset = 1'b1;
		uart_line = 1'b1;
		bus_req = '0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		drive_edge();

		send_frame(8'h5a, 1'b0);
		irq_expected++;
		wait_interrupts("single_byte_interrupt", irq_expected);
		bus_read("single_byte_status", ADDR_STATUS);
		bus_read("single_byte_data", ADDR_DATA);
		bus_read("single_byte_status_empty", ADDR_STATUS);

		for (int i = 0; i < 20; i++) begin
			value = $random(seed);
			send_frame(value, 1'b0);
			irq_expected++;
			wait_interrupts("order_interrupt", irq_expected);
			bus_read("order_data", ADDR_DATA);
		end

		// Low stop bit, then a short glitch on the idle line.
		send_frame(8'h33, 1'b1);
		uart_line = 1'b0;
		repeat (4) drive_edge();
		uart_line = 1'b1;
		repeat (2 * BIT_CLOCKS) drive_edge();
		check_value("bad_frames_interrupts", irq_expected, irq_count);
		bus_read("bad_frames_status", ADDR_STATUS);

		for (int i = 0; i < 10; i++) begin
			send_frame(8'(8'h80 + i), 1'b0);
		end
		irq_expected += 10;
		wait_interrupts("overflow_interrupts", irq_expected);
		bus_read("overflow_status_full", ADDR_STATUS);
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			bus_read("overflow_data", ADDR_DATA);
		end
		bus_read("overflow_status_empty", ADDR_STATUS);

		soft_base = soft_count;
		send_frame(8'hff, 1'b0);
		irq_expected++;
		wait_interrupts("soft_reset_ff_interrupt", irq_expected);
		check_value("soft_reset_ff_pulse", soft_base + 1, soft_count);
		send_frame(8'hfe, 1'b0);
		irq_expected++;
		wait_interrupts("soft_reset_fe_interrupt", irq_expected);
		check_value("soft_reset_fe_pulse", soft_base + 1, soft_count);
		bus_read("soft_reset_data_ff", ADDR_DATA);
		bus_read("soft_reset_data_fe", ADDR_DATA);

		// Address 2 must leave the queued byte in place.
		send_frame(8'h3c, 1'b0);
		irq_expected++;
		wait_interrupts("unused_address_interrupt", irq_expected);
		bus_read("unused_address", 2'd2);
		bus_read("unused_address_status", ADDR_STATUS);
		bus_read("unused_address_data", ADDR_DATA);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
